// ==== lsqPkg.sv ====
package lsqPkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int NUM_PHYS_REGS = 64;
    localparam int TAG_W         = $clog2(NUM_PHYS_REGS);
    localparam int LSQ_DEPTH     = 8;
    localparam int LSQ_IDX_W     = $clog2(LSQ_DEPTH);
    localparam int CNT_W         = LSQ_IDX_W + 1;   // count runs 0..LSQ_DEPTH

    localparam int DMEM_WORDS    = 16;
    localparam int DMEM_IDX_W    = $clog2(DMEM_WORDS);
    localparam int WORD_LSB      = 2;               // byte offset bits below the word index

    // ----------------------------------------
    // dispatch side
    // ----------------------------------------

    // one load or store in program order, address not known yet
    typedef struct packed {
        logic             isStore;
        logic [TAG_W-1:0] tag;
        logic [31:0]      storeData;
    } memOpT;

    // address from the AGU, matched to an entry by tag
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      addr;
    } addrUpdT;

    localparam int UPD_PAD_W = $bits(memOpT) - $bits(addrUpdT);

    typedef struct packed {
        logic [UPD_PAD_W-1:0] pad;  // unused, always zero
        addrUpdT              agu;
    } addrUpdPadT;

    // command body, isUpdate picks the view
    typedef union packed {
        memOpT      op;
        addrUpdPadT upd;
    } lsqCmdU;

    typedef struct packed {
        logic   valid;
        logic   isUpdate;
        lsqCmdU body;
    } lsqCmdT;

    // ----------------------------------------
    // queue and memory side
    // ----------------------------------------
    typedef struct packed {
        logic             isStore;
        logic             addrReady;
        logic [TAG_W-1:0] tag;
        logic [31:0]      addr;
        logic [31:0]      storeData;
    } lsqEntryT;

    typedef struct packed {
        logic             valid;
        logic             isStore;
        logic [TAG_W-1:0] tag;
        logic [31:0]      addr;
        logic [31:0]      storeData;
    } memReqT;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;   // physical destination
        logic [31:0]      data;
    } loadRespT;

endpackage

// ==== lsqDispatch.sv ====
`timescale 1ns/100ps

module lsqDispatch import lsqPkg::*; (
    input  logic    CLK,
    input  logic    RESET,
    input  logic    FLUSH,
    input  logic    dispatchValid,
    input  memOpT   dispatchOp,
    input  logic    aguValid,
    input  addrUpdT aguUpd,
    input  logic    full,
    output lsqCmdT  cmd,
    output logic    dispatchReject
);

    logic    acceptOp;
    logic    pendValid;        // one parked update
    logic    pendValidNext;
    addrUpdT pendUpd;
    addrUpdT pendUpdNext;
    lsqCmdT  cmdNext;

    // wrap an AGU result as an update command
    function automatic lsqCmdT mkUpdCmd(input addrUpdT u);
        lsqCmdT c;
        c = '0;
        c.valid          = 1'b1;
        c.isUpdate       = 1'b1;
        c.body.upd.pad   = '0;
        c.body.upd.agu   = u;
        return c;
    endfunction

    assign acceptOp = dispatchValid && !full;

    // ----------------------------------------
    // pick one command per cycle
    // ----------------------------------------
    always_comb begin
        cmdNext       = '0;
        pendValidNext = pendValid;
        pendUpdNext   = pendUpd;
        if (acceptOp) begin
            // dispatch wins, a colliding update gets parked
            cmdNext.valid    = 1'b1;
            cmdNext.isUpdate = 1'b0;
            cmdNext.body.op  = dispatchOp;
            if (aguValid) begin
                pendValidNext = 1'b1;
                pendUpdNext   = aguUpd;
            end
        end else if (pendValid) begin
            cmdNext = mkUpdCmd(pendUpd);  // drain oldest first
            if (aguValid) begin
                pendUpdNext = aguUpd;     // slot refills right away
            end else begin
                pendValidNext = 1'b0;
            end
        end else if (aguValid) begin
            cmdNext = mkUpdCmd(aguUpd);
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            cmd            <= '0;
            dispatchReject <= 1'b0;
            pendValid      <= 1'b0;
        end else if (FLUSH) begin
            cmd            <= '0;
            dispatchReject <= 1'b0;
            pendValid      <= 1'b0;   // parked update is dropped too
        end else begin
            cmd            <= cmdNext;
            dispatchReject <= dispatchValid && full;
            pendValid      <= pendValidNext;
        end
    end

    always_ff @(posedge CLK) begin
        pendUpd <= pendUpdNext;
    end

    // a second update landing on a parked one that is not drained this cycle
    assert property (@(posedge CLK) disable iff (!RESET)
        !FLUSH |-> !(pendValid && acceptOp && aguValid))
        else $error("lsqDispatch: pending update overwritten");

endmodule

// ==== lsqQueue.sv ====
`timescale 1ns/100ps

module lsqQueue import lsqPkg::*; (
    input  logic   CLK,
    input  logic   RESET,
    input  logic   FLUSH,
    input  lsqCmdT cmd,
    output logic   full,
    output memReqT issue,
    output logic   updateMiss
);

    lsqEntryT             entries [LSQ_DEPTH];
    logic [LSQ_DEPTH-1:0] entryValid;
    logic [LSQ_IDX_W-1:0] head;
    logic [LSQ_IDX_W-1:0] tail;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     countNext;

    memOpT                newOp;
    addrUpdT              upd;
    logic                 cmdEnq;
    logic                 cmdUpd;
    logic                 headReady;
    logic                 doEnq;
    logic [LSQ_DEPTH-1:0] tagMatch;

    // ----------------------------------------
    // command decode
    // ----------------------------------------
    assign newOp  = cmd.body.op;
    assign upd    = cmd.body.upd.agu;
    assign cmdEnq = cmd.valid && !cmd.isUpdate;
    assign cmdUpd = cmd.valid && cmd.isUpdate;

    // only the head may go, a waiting head blocks everything behind it
    assign headReady = entryValid[head] && entries[head].addrReady;

    // issue frees the slot first when the queue is full
    assign doEnq = cmdEnq && ((count < CNT_W'(LSQ_DEPTH)) || headReady);

    assign countNext = count + CNT_W'(doEnq) - CNT_W'(headReady);

    // tags are unique among valid entries, so at most one bit is set
    always_comb begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            tagMatch[i] = entryValid[i] && (entries[i].tag == upd.tag);
        end
    end

    // ----------------------------------------
    // pointers, valid bits, outputs
    // ----------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            entryValid <= '0;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            full       <= 1'b0;
            updateMiss <= 1'b0;
            issue      <= '0;
        end else if (FLUSH) begin
            entryValid <= '0;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            full       <= 1'b0;
            updateMiss <= 1'b0;
            issue      <= '0;
        end else begin
            if (headReady) begin
                entryValid[head] <= 1'b0;
                head             <= head + LSQ_IDX_W'(1);
            end
            // after the issue clear, so a refilled slot stays valid
            if (doEnq) begin
                entryValid[tail] <= 1'b1;
                tail             <= tail + LSQ_IDX_W'(1);
            end
            count <= countNext;

            // raised one slot early: dispatch samples this a cycle late and
            // may already have an enqueue on its way
            full <= (countNext >= CNT_W'(LSQ_DEPTH - 1));

            updateMiss <= cmdUpd && (tagMatch == '0);

            issue.valid     <= headReady;
            issue.isStore   <= entries[head].isStore;
            issue.tag       <= entries[head].tag;
            issue.addr      <= entries[head].addr;
            issue.storeData <= entries[head].storeData;
        end
    end

    // ----------------------------------------
    // entry storage
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (doEnq) begin
            entries[tail] <= '{
                isStore:   newOp.isStore,
                addrReady: 1'b0,          // waits for its AGU result
                tag:       newOp.tag,
                addr:      '0,
                storeData: newOp.storeData
            };
        end
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (cmdUpd && tagMatch[i]) begin
                entries[i].addrReady <= 1'b1;
                entries[i].addr      <= upd.addr;
            end
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    assert property (@(posedge CLK) disable iff (!RESET)
        count <= CNT_W'(LSQ_DEPTH))
        else $error("lsqQueue: count above depth");

    // dispatch must never send an enqueue the queue has to drop
    assert property (@(posedge CLK) disable iff (!RESET)
        (cmdEnq && !FLUSH) |-> doEnq)
        else $error("lsqQueue: enqueue while full");

endmodule

// ==== memAccess.sv ====
`timescale 1ns/100ps

module memAccess import lsqPkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  memReqT   issue,
    output loadRespT loadResp
);

    logic [31:0]           dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] wordIdx;
    logic                  isLoad;
    logic                  isStoreReq;

    assign wordIdx    = issue.addr[WORD_LSB +: DMEM_IDX_W];  // upper bits ignored
    assign isLoad     = issue.valid && !issue.isStore;
    assign isStoreReq = issue.valid && issue.isStore;

    // ----------------------------------------
    // data memory
    // ----------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (isStoreReq) begin
            dmem[wordIdx] <= issue.storeData;  // visible to a load issued next cycle
        end
    end

    // ----------------------------------------
    // load result, one edge after issue
    // ----------------------------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            loadResp <= '0;
        end else begin
            loadResp.valid <= isLoad;
            loadResp.tag   <= issue.tag;
            loadResp.data  <= dmem[wordIdx];
        end
    end

    // addresses come straight from the AGU through the queue
    assert property (@(posedge CLK) disable iff (!RESET)
        issue.valid |-> (issue.addr[WORD_LSB-1:0] == '0))
        else $error("memAccess: unaligned address %h", issue.addr);

endmodule

// ==== lsqTop.sv ====
`timescale 1ns/100ps

module lsqTop import lsqPkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     FLUSH,
    input  logic     dispatchValid,
    input  memOpT    dispatchOp,
    input  logic     aguValid,
    input  addrUpdT  aguUpd,
    output logic     dispatchReject,
    output logic     updateMiss,
    output loadRespT loadResp
);

    lsqCmdT cmd;     // dispatch to queue
    logic   full;    // queue back to dispatch
    memReqT issue;   // queue to memory

    // ----------------------------------------
    // producer
    // ----------------------------------------
    lsqDispatch lsqDispatch_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .FLUSH          (FLUSH),
        .dispatchValid  (dispatchValid),
        .dispatchOp     (dispatchOp),
        .aguValid       (aguValid),
        .aguUpd         (aguUpd),
        .full           (full),
        .cmd            (cmd),
        .dispatchReject (dispatchReject)
    );

    // ----------------------------------------
    // buffer
    // ----------------------------------------
    lsqQueue lsqQueue_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .FLUSH      (FLUSH),
        .cmd        (cmd),
        .full       (full),
        .issue      (issue),
        .updateMiss (updateMiss)
    );

    // ----------------------------------------
    // consumer, memory survives a flush
    // ----------------------------------------
    memAccess memAccess_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .issue    (issue),
        .loadResp (loadResp)
    );

endmodule

// ==== lsqTb.sv ====
`timescale 1ns/100ps

module lsqTb import lsqPkg::*; ();

    localparam int TEST_BOUND     = 300;       // cycles any one test may need
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_BOUND + 200;
    localparam int MAX_OPS        = 256;

    logic     CLK;
    logic     RESET;
    logic     FLUSH;
    logic     dispatchValid;
    memOpT    dispatchOp;
    logic     aguValid;
    addrUpdT  aguUpd;
    logic     dispatchReject;
    logic     updateMiss;
    loadRespT loadResp;

    // ops in program order with the index modulo the register count as tag
    logic        opStore [MAX_OPS];
    logic [31:0] opAddr  [MAX_OPS];
    logic [31:0] opData  [MAX_OPS];
    int          opCount;

    logic [31:0]      modelMem [DMEM_WORDS];
    logic [TAG_W-1:0] expTag   [$];
    logic [31:0]      expData  [$];
    logic [TAG_W-1:0] gotTag   [$];
    logic [31:0]      gotData  [$];

    int rejectCount;
    int missCount;
    int cycleCount;
    int checkCount;
    int errorCount;
    int testErrors;

    lsqTop lsqTop_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .FLUSH          (FLUSH),
        .dispatchValid  (dispatchValid),
        .dispatchOp     (dispatchOp),
        .aguValid       (aguValid),
        .aguUpd         (aguUpd),
        .dispatchReject (dispatchReject),
        .updateMiss     (updateMiss),
        .loadResp       (loadResp)
    );

    always #2 CLK = ~CLK;   // 4 ns period

    // ----------------------------------------
    // monitor and run limit
    // ----------------------------------------
    always @(posedge CLK) begin
        if (RESET) begin
            if (loadResp.valid) begin
                gotTag.push_back(loadResp.tag);
                gotData.push_back(loadResp.data);
            end
            if (dispatchReject) begin
                rejectCount++;
            end
            if (updateMiss) begin
                missCount++;
            end
        end
    end

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("run stopped, still busy after %0d cycles", cycleCount);
            $display("test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // op bookkeeping and reference model
    // ----------------------------------------
    function automatic logic [TAG_W-1:0] tagOf(input int idx);
        return TAG_W'(idx % NUM_PHYS_REGS);
    endfunction

    function automatic logic [31:0] pickAddr(input int span);
        logic [DMEM_IDX_W-1:0] w;
        w = DMEM_IDX_W'($urandom % span);
        return 32'(w) << WORD_LSB;
    endfunction

    function automatic int makeOp(input logic isStore, input logic [31:0] addr,
                                  input logic [31:0] data);
        int idx;
        idx          = opCount;
        opStore[idx] = isStore;
        opAddr[idx]  = addr;
        opData[idx]  = isStore ? data : 32'h0;
        opCount      = (opCount + 1) % MAX_OPS;
        return idx;
    endfunction

    // memory executes in program order, so a load sees every older store
    function automatic void modelExec(input int idx);
        logic [DMEM_IDX_W-1:0] w;
        w = opAddr[idx][WORD_LSB +: DMEM_IDX_W];
        if (opStore[idx]) begin
            modelMem[w] = opData[idx];
        end else begin
            expTag.push_back(tagOf(idx));
            expData.push_back(modelMem[w]);
        end
    endfunction

    function automatic addrUpdT updOf(input int idx);
        addrUpdT u;
        u.tag  = tagOf(idx);
        u.addr = opAddr[idx];
        return u;
    endfunction

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic driveCycle(input logic dv, input int dIdx, input logic av, input addrUpdT u);
        @(posedge CLK);
        dispatchValid <= dv;
        aguValid      <= av;
        dispatchOp    <= '{isStore: opStore[dIdx], tag: tagOf(dIdx), storeData: opData[dIdx]};
        aguUpd        <= u;
    endtask

    task automatic dispatch(input int idx);
        driveCycle(1'b1, idx, 1'b0, '0);
    endtask

    task automatic update(input int idx);
        driveCycle(1'b0, 0, 1'b1, updOf(idx));
    endtask

    task automatic idle(input int n);
        repeat (n) driveCycle(1'b0, 0, 1'b0, '0);
    endtask

    task automatic pulseFlush();
        @(posedge CLK);
        FLUSH <= 1'b1;
        @(posedge CLK);
        FLUSH <= 1'b0;
    endtask

    // ----------------------------------------
    // checking
    // ----------------------------------------
    task automatic checkVal(input string sig, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got == exp) else begin
            $display("error: %s got %h expected %h", sig, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkTrue(input logic ok, input string what);
        checkCount++;
        assert (ok) else begin
            $display("%s", what);
            testErrors++;
        end
    endtask

    task automatic waitLoads(input int n);
        int waited;
        waited = 0;
        idle(1);
        while (gotTag.size() < n && waited < TEST_BOUND) begin
            idle(1);
            waited++;
        end
        checkTrue(gotTag.size() >= n,
            $sformatf("gave up waiting for %0d load results after %0d cycles", n, waited));
    endtask

    // results must match the expected list one for one, in program order
    task automatic checkLoads();
        checkTrue(gotTag.size() == expTag.size(),
            $sformatf("%0d load results arrived, %0d were expected", gotTag.size(),
                      expTag.size()));
        while (gotTag.size() > 0 && expTag.size() > 0) begin
            checkVal("loadResp.tag", 32'(gotTag.pop_front()), 32'(expTag.pop_front()));
            checkVal("loadResp.data", gotData.pop_front(), expData.pop_front());
        end
        gotTag.delete();
        gotData.delete();
        expTag.delete();
        expData.delete();
    endtask

    task automatic endTest(input string name);
        $display("[%0s] done, %0d errors", name, testErrors);
        errorCount += testErrors;
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic storeThenLoad();
        int          s;
        int          l;
        logic [31:0] a;
        testErrors = 0;
        a = pickAddr(DMEM_WORDS);
        s = makeOp(1'b1, a, $urandom);
        l = makeOp(1'b0, a, 32'h0);
        modelExec(s);
        modelExec(l);
        dispatch(s);
        dispatch(l);
        update(s);
        update(l);
        waitLoads(1);
        idle(4);
        checkLoads();
        endTest("store then load");
    endtask

    task automatic outOfOrderUpdates();
        int ids   [6];
        int order [6];
        int j;
        int t;
        testErrors = 0;
        for (int i = 0; i < 6; i++) begin
            // few words so loads hit older stores and the last op is always a load
            ids[i] = makeOp((i < 5) && ($urandom % 2 == 1), pickAddr(4), $urandom);
            modelExec(ids[i]);
            order[i] = i;
        end
        for (int i = 5; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < 6; i++) begin
            dispatch(ids[i]);
        end
        for (int i = 0; i < 6; i++) begin
            update(ids[order[i]]);
        end
        waitLoads(expTag.size());
        idle(4);
        checkLoads();
        endTest("out-of-order updates");
    endtask

    task automatic fullReject();
        int ids [9];
        int rej0;
        int miss0;
        testErrors = 0;
        rej0  = rejectCount;
        miss0 = missCount;
        for (int i = 0; i < 9; i++) begin
            ids[i] = makeOp(1'b0, pickAddr(DMEM_WORDS), 32'h0);
        end
        for (int i = 0; i < 9; i++) begin
            dispatch(ids[i]);     // back to back so the ninth meets a full queue
        end
        idle(3);
        checkVal("dispatchReject count", rejectCount - rej0, 1);
        for (int i = 0; i < 8; i++) begin
            modelExec(ids[i]);
            update(ids[i]);
        end
        waitLoads(8);
        idle(4);
        checkLoads();
        modelExec(ids[8]);        // retry once drained
        dispatch(ids[8]);
        update(ids[8]);
        waitLoads(1);
        idle(4);
        checkLoads();
        checkVal("dispatchReject count", rejectCount - rej0, 1);
        checkVal("updateMiss count", missCount - miss0, 0);
        endTest("full queue rejection");
    endtask

    task automatic unmatchedUpdate();
        int      l;
        int      miss0;
        addrUpdT bad;
        testErrors = 0;
        miss0 = missCount;
        l = makeOp(1'b0, pickAddr(DMEM_WORDS), 32'h0);
        modelExec(l);
        dispatch(l);
        bad.tag  = tagOf(l) ^ TAG_W'(NUM_PHYS_REGS / 2);
        bad.addr = pickAddr(DMEM_WORDS);
        driveCycle(1'b0, 0, 1'b1, bad);
        idle(6);
        checkVal("updateMiss count", missCount - miss0, 1);
        checkTrue(gotTag.size() == 0, "a load result appeared for an unmatched update");
        update(l);
        waitLoads(1);
        idle(4);
        checkLoads();
        checkVal("updateMiss count", missCount - miss0, 1);
        endTest("unmatched update");
    endtask

    task automatic collidingUpdate();
        int          s;
        int          l1;
        int          l2;
        int          miss0;
        logic [31:0] a;
        testErrors = 0;
        miss0 = missCount;
        a  = pickAddr(DMEM_WORDS);
        s  = makeOp(1'b1, a, $urandom);
        l1 = makeOp(1'b0, a, 32'h0);
        l2 = makeOp(1'b0, pickAddr(DMEM_WORDS), 32'h0);
        modelExec(s);
        modelExec(l1);
        modelExec(l2);
        dispatch(s);
        driveCycle(1'b1, l1, 1'b1, updOf(s));   // update for s parked behind l1
        update(l1);                             // drains s, parks l1
        dispatch(l2);                           // l1 stays parked
        update(l2);
        waitLoads(2);
        idle(4);
        checkLoads();
        checkVal("updateMiss count", missCount - miss0, 0);
        endTest("update beside dispatch");
    endtask

    task automatic flushKeepsMemory();
        int          s;
        int          l1;
        int          l2;
        int          s2;
        int          s3;
        int          l3;
        int          l4;
        int          miss0;
        logic [31:0] a;
        logic [31:0] c;
        testErrors = 0;
        miss0 = missCount;
        a = pickAddr(DMEM_WORDS);
        c = (a + 32'h4) & 32'h3c;    // another word
        s = makeOp(1'b1, a, $urandom);
        modelExec(s);
        dispatch(s);
        update(s);
        idle(8);
        // blocked behind l1 and never executed
        l1 = makeOp(1'b0, pickAddr(DMEM_WORDS), 32'h0);
        l2 = makeOp(1'b0, pickAddr(DMEM_WORDS), 32'h0);
        s2 = makeOp(1'b1, a, ~opData[s]);
        dispatch(l1);
        dispatch(l2);
        dispatch(s2);
        update(l2);
        update(s2);
        idle(4);
        pulseFlush();
        update(l1);                  // would release the whole group if it had survived
        idle(20);
        checkTrue(gotTag.size() == 0, "load results came out of a flushed queue");
        checkVal("updateMiss count", missCount - miss0, 1);
        s3 = makeOp(1'b1, c, $urandom);
        l3 = makeOp(1'b0, c, 32'h0);
        l4 = makeOp(1'b0, a, 32'h0);
        modelExec(s3);
        modelExec(l3);
        modelExec(l4);
        dispatch(s3);
        dispatch(l3);
        dispatch(l4);
        update(s3);
        update(l3);
        update(l4);
        waitLoads(2);
        idle(4);
        checkLoads();
        endTest("flush keeps memory");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        CLK           = 1'b0;
        RESET         = 1'b0;
        FLUSH         = 1'b0;
        dispatchValid = 1'b0;
        dispatchOp    = '0;
        aguValid      = 1'b0;
        aguUpd        = '0;
        opCount       = 0;
        rejectCount   = 0;
        missCount     = 0;
        cycleCount    = 0;
        checkCount    = 0;
        errorCount    = 0;
        testErrors    = 0;
        void'($urandom(2));
        for (int i = 0; i < DMEM_WORDS; i++) begin
            modelMem[i] = 32'h0;    // DUT memory clears at reset
        end
        for (int i = 0; i < MAX_OPS; i++) begin
            opStore[i] = 1'b0;
            opAddr[i]  = 32'h0;
            opData[i]  = 32'h0;
        end
        repeat (8) @(posedge CLK);
        RESET <= 1'b1;
        idle(2);

        storeThenLoad();
        outOfOrderUpdates();
        fullReject();
        unmatchedUpdate();
        collidingUpdate();
        flushKeepsMemory();

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
lsqPkg.sv
lsqDispatch.sv
lsqQueue.sv
memAccess.sv
lsqTop.sv
lsqTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsqTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the simulator output
run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
